// ==== rtl/ooo_pkg.sv ====
// Shared widths and depths for the dispatch front end
// RISC-V major opcode and ROB operation class enums

package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int NREGS     = 1 << REG_AW;
    localparam int TAG_W     = 3;
    localparam int ROB_DEPTH = 8;
    localparam int RS_DEPTH  = 4;
    localparam int RS_IW     = $clog2(RS_DEPTH);
    localparam int IQ_DEPTH  = 4;
    localparam int IQ_AW     = $clog2(IQ_DEPTH);

    // Major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP     = 7'b0110011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [1:0] {
        ROB_OP_INT = 2'd0,
        ROB_OP_BR  = 2'd1,
        ROB_OP_LD  = 2'd2,
        ROB_OP_ST  = 2'd3
    } rob_op_t;

endpackage

// ==== rtl/ooo_ifs.sv ====
// Dispatch to ROB interface, allocation and operand lookup
// Dispatch to reservation station interface, entry write

`timescale 1ns/1ps

interface rob_dispatch_if import ooo_pkg::*; ();

    logic              en;
    rob_op_t           op;
    logic [XLEN-1:0]   iaddr;
    logic [REG_AW-1:0] rdest;
    logic [REG_AW-1:0] rsrc     [2];
    logic              stall;
    logic [TAG_W-1:0]  tag;
    // Lookup results for rsrc
    logic [TAG_W-1:0]  src_tag  [2];
    logic [XLEN-1:0]   src_data [2];
    logic              src_rdy  [2];

    modport disp (output en, op, iaddr, rdest, rsrc,
                  input  stall, tag, src_tag, src_data, src_rdy);
    modport rob  (input  en, op, iaddr, rdest, rsrc,
                  output stall, tag, src_tag, src_data, src_rdy);

endinterface

interface rs_dispatch_if import ooo_pkg::*; ();

    logic             en;
    opcode_t          opcode;
    logic [XLEN-1:0]  iaddr;
    logic [XLEN-1:0]  insn;
    logic [TAG_W-1:0] src_tag  [2];
    logic [XLEN-1:0]  src_data [2];
    logic             src_rdy  [2];
    logic [TAG_W-1:0] dst_tag;
    logic             stall;

    modport disp (output en, opcode, iaddr, insn, src_tag, src_data, src_rdy, dst_tag,
                  input  stall);
    modport rs   (input  en, opcode, iaddr, insn, src_tag, src_data, src_rdy, dst_tag,
                  output stall);

endinterface

// ==== rtl/insn_queue.sv ====
// Instruction queue
// Circular FIFO holding instruction word and address pairs

`timescale 1ns/1ps

module insn_queue import ooo_pkg::*; (
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_push,
    input  logic [XLEN-1:0] i_insn,
    input  logic [XLEN-1:0] i_iaddr,
    input  logic            i_pop,
    output logic            o_empty,
    output logic            o_full,
    output logic [XLEN-1:0] o_insn,
    output logic [XLEN-1:0] o_iaddr
);

    // Word and address kept side by side in one entry
    logic [2*XLEN-1:0] mem [IQ_DEPTH];
    logic [IQ_AW-1:0]  wptr;
    logic [IQ_AW-1:0]  rptr;
    logic [IQ_AW:0]    count;

    assign o_empty = (count == '0);
    assign o_full  = (count == (IQ_AW+1)'(IQ_DEPTH));

    // Head entry is visible without a read cycle
    assign {o_insn, o_iaddr} = mem[rptr];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                wptr <= wptr + 1'b1;
            end
            if (i_pop) begin
                rptr <= rptr + 1'b1;
            end
            if (i_push && !i_pop) begin
                count <= count + 1'b1;
            end else if (i_pop && !i_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wptr] <= {i_insn, i_iaddr};
        end
    end

    // Producer must honour o_full and dispatch must honour o_empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_push && o_full) && !(i_pop && o_empty));

endmodule

// ==== rtl/dispatch.sv ====
// Dispatch stage
// Decodes the head instruction, applies operand readiness per opcode
// and allocates ROB and reservation station entries together

`timescale 1ns/1ps

module dispatch import ooo_pkg::*; (
    input  logic            i_empty,
    input  logic [XLEN-1:0] i_insn,
    input  logic [XLEN-1:0] i_iaddr,
    output logic            o_pop,
    rob_dispatch_if.disp    rob,
    rs_dispatch_if.disp     rs
);

    logic [6:0]        opcode;
    logic [REG_AW-1:0] rdest;
    logic              use_lookup [2];
    logic              enable;

    assign opcode      = i_insn[6:0];
    assign rdest       = i_insn[11:7];
    assign rob.rsrc[0] = i_insn[19:15];
    assign rob.rsrc[1] = i_insn[24:20];

    // Both sides allocate in the same cycle, so either one can hold dispatch
    assign enable = !i_empty && !rob.stall && !rs.stall;
    assign o_pop  = enable;
    assign rob.en = enable;
    assign rs.en  = enable;

    assign rob.iaddr  = i_iaddr;
    assign rs.iaddr   = i_iaddr;
    assign rs.insn    = i_insn;
    assign rs.dst_tag = rob.tag;

    // Operands not read by the opcode are forced ready
    always_comb begin
        rs.opcode     = opcode_t'(opcode);
        use_lookup[0] = 1'b0;
        use_lookup[1] = 1'b0;
        rob.op        = ROB_OP_INT;
        rob.rdest     = rdest;
        case (opcode)
            OPCODE_OPIMM:  use_lookup[0] = 1'b1;
            OPCODE_LUI, OPCODE_AUIPC: ;
            OPCODE_OP: begin
                use_lookup[0] = 1'b1;
                use_lookup[1] = 1'b1;
            end
            OPCODE_JAL:    rob.op = ROB_OP_BR;
            OPCODE_JALR: begin
                use_lookup[0] = 1'b1;
                rob.op        = ROB_OP_BR;
            end
            OPCODE_BRANCH: begin
                use_lookup[0] = 1'b1;
                use_lookup[1] = 1'b1;
                rob.op        = ROB_OP_BR;
                rob.rdest     = '0;
            end
            OPCODE_LOAD: begin
                use_lookup[0] = 1'b1;
                rob.op        = ROB_OP_LD;
            end
            OPCODE_STORE: begin
                use_lookup[0] = 1'b1;
                use_lookup[1] = 1'b1;
                rob.op        = ROB_OP_ST;
                rob.rdest     = '0;
            end
            default: begin
                // unknown opcodes travel as a no-op immediate
                rs.opcode = OPCODE_OPIMM;
                rob.rdest = '0;
            end
        endcase
    end

    for (genvar i = 0; i < 2; i++) begin : g_src
        assign rs.src_tag[i]  = rob.src_tag[i];
        assign rs.src_data[i] = rob.src_data[i];
        assign rs.src_rdy[i]  = use_lookup[i] ? rob.src_rdy[i] : 1'b1;
    end

endmodule

// ==== rtl/rob.sv ====
// Reorder buffer
// Register alias table, architectural register file, source lookup,
// CDB completion and in-order commit

`timescale 1ns/1ps

module rob import ooo_pkg::*; (
    input  logic              clk,
    input  logic              i_arst_n,
    rob_dispatch_if.rob       rob,
    input  logic              i_cdb_valid,
    input  logic [TAG_W-1:0]  i_cdb_tag,
    input  logic [XLEN-1:0]   i_cdb_data,
    output logic              o_commit_valid,
    output rob_op_t           o_commit_op,
    output logic [REG_AW-1:0] o_commit_rdest,
    output logic [XLEN-1:0]   o_commit_data,
    output logic [XLEN-1:0]   o_commit_iaddr
);

    // Entry array
    rob_op_t           ent_op    [ROB_DEPTH];
    logic [REG_AW-1:0] ent_rdest [ROB_DEPTH];
    logic [XLEN-1:0]   ent_iaddr [ROB_DEPTH];
    logic [XLEN-1:0]   ent_data  [ROB_DEPTH];
    logic              ent_done  [ROB_DEPTH];
    logic [TAG_W-1:0]  head;
    logic [TAG_W-1:0]  tail;
    logic [TAG_W:0]    count;

    // Alias table and register file
    logic              rat_busy [NREGS];
    logic [TAG_W-1:0]  rat_tag  [NREGS];
    logic [XLEN-1:0]   regfile  [NREGS];

    logic              commit;
    logic [TAG_W-1:0]  cdb_off;

    assign rob.stall = (count == (TAG_W+1)'(ROB_DEPTH));
    assign rob.tag   = tail;
    assign commit    = (count != '0) && ent_done[head];
    assign cdb_off   = i_cdb_tag - head;

    // Source lookup from current state only
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rob.src_tag[i] = rat_tag[rob.rsrc[i]];
            if (rob.rsrc[i] == '0 || !rat_busy[rob.rsrc[i]]) begin
                rob.src_data[i] = regfile[rob.rsrc[i]];
                rob.src_rdy[i]  = 1'b1;
            end else if (ent_done[rat_tag[rob.rsrc[i]]]) begin
                rob.src_data[i] = ent_data[rat_tag[rob.rsrc[i]]];
                rob.src_rdy[i]  = 1'b1;
            end else begin
                rob.src_data[i] = '0;
                rob.src_rdy[i]  = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            o_commit_valid <= 1'b0;
            for (int e = 0; e < ROB_DEPTH; e++) begin
                ent_done[e] <= 1'b0;
            end
            for (int r = 0; r < NREGS; r++) begin
                rat_busy[r] <= 1'b0;
                regfile[r]  <= '0;
            end
        end else begin
            o_commit_valid <= commit;
            if (commit) begin
                head <= head + 1'b1;
                if (ent_rdest[head] != '0) begin
                    regfile[ent_rdest[head]] <= ent_data[head];
                end
                // A younger writer of the same register keeps its mapping
                if (rat_tag[ent_rdest[head]] == head) begin
                    rat_busy[ent_rdest[head]] <= 1'b0;
                end
            end
            // Allocation comes last so it wins over a same-edge commit clear
            if (rob.en) begin
                tail           <= tail + 1'b1;
                ent_done[tail] <= 1'b0;
                if (rob.rdest != '0) begin
                    rat_busy[rob.rdest] <= 1'b1;
                end
            end
            if (i_cdb_valid) begin
                ent_done[i_cdb_tag] <= 1'b1;
            end
            if (rob.en && !commit) begin
                count <= count + 1'b1;
            end else if (commit && !rob.en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rob.en) begin
            ent_op[tail]    <= rob.op;
            ent_rdest[tail] <= rob.rdest;
            ent_iaddr[tail] <= rob.iaddr;
            if (rob.rdest != '0) begin
                rat_tag[rob.rdest] <= tail;
            end
        end
        if (i_cdb_valid) begin
            ent_data[i_cdb_tag] <= i_cdb_data;
        end
        if (commit) begin
            o_commit_op    <= ent_op[head];
            o_commit_rdest <= ent_rdest[head];
            o_commit_data  <= ent_data[head];
            o_commit_iaddr <= ent_iaddr[head];
        end
    end

    // Results may only come back for tags that are in flight
    a_cdb_allocated: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_cdb_valid |-> ((TAG_W+1)'(cdb_off) < count));

endmodule

// ==== rtl/res_station.sv ====
// Reservation station
// Slots with CDB operand wakeup, free slot allocation and
// single issue of the lowest ready slot per cycle

`timescale 1ns/1ps

module res_station import ooo_pkg::*; (
    input  logic             clk,
    input  logic             i_arst_n,
    rs_dispatch_if.rs        rs,
    input  logic             i_cdb_valid,
    input  logic [TAG_W-1:0] i_cdb_tag,
    input  logic [XLEN-1:0]  i_cdb_data,
    output logic             o_issue_valid,
    output opcode_t          o_issue_opcode,
    output logic [TAG_W-1:0] o_issue_tag,
    output logic [XLEN-1:0]  o_issue_insn,
    output logic [XLEN-1:0]  o_issue_iaddr,
    output logic [XLEN-1:0]  o_issue_src_data [2]
);

    logic             busy     [RS_DEPTH];
    opcode_t          s_opcode [RS_DEPTH];
    logic [XLEN-1:0]  s_iaddr  [RS_DEPTH];
    logic [XLEN-1:0]  s_insn   [RS_DEPTH];
    logic [TAG_W-1:0] s_dst    [RS_DEPTH];
    logic [TAG_W-1:0] s_tag    [RS_DEPTH][2];
    logic [XLEN-1:0]  s_data   [RS_DEPTH][2];
    logic             s_rdy    [RS_DEPTH][2];

    logic             free_found;
    logic [RS_IW-1:0] free_idx;
    logic             iss_found;
    logic [RS_IW-1:0] iss_idx;
    logic             in_rdy  [2];
    logic [XLEN-1:0]  in_data [2];

    // Lowest free slot and lowest ready slot, scanned downwards
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        iss_found  = 1'b0;
        iss_idx    = '0;
        for (int s = RS_DEPTH - 1; s >= 0; s--) begin
            if (!busy[s]) begin
                free_found = 1'b1;
                free_idx   = RS_IW'(s);
            end
            if (busy[s] && s_rdy[s][0] && s_rdy[s][1]) begin
                iss_found = 1'b1;
                iss_idx   = RS_IW'(s);
            end
        end
    end

    assign rs.stall = !free_found;

    // Incoming operands also catch a broadcast in the write cycle
    for (genvar j = 0; j < 2; j++) begin : g_in
        assign in_rdy[j]  = rs.src_rdy[j] || (i_cdb_valid && i_cdb_tag == rs.src_tag[j]);
        assign in_data[j] = rs.src_rdy[j] ? rs.src_data[j] : i_cdb_data;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_issue_valid <= 1'b0;
            for (int s = 0; s < RS_DEPTH; s++) begin
                busy[s] <= 1'b0;
            end
        end else begin
            o_issue_valid <= iss_found;
            if (iss_found) begin
                busy[iss_idx] <= 1'b0;
            end
            if (rs.en) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Wakeup of waiting operands
        for (int s = 0; s < RS_DEPTH; s++) begin
            for (int j = 0; j < 2; j++) begin
                if (busy[s] && !s_rdy[s][j] && i_cdb_valid && s_tag[s][j] == i_cdb_tag) begin
                    s_rdy[s][j]  <= 1'b1;
                    s_data[s][j] <= i_cdb_data;
                end
            end
        end
        if (rs.en) begin
            s_opcode[free_idx] <= rs.opcode;
            s_iaddr[free_idx]  <= rs.iaddr;
            s_insn[free_idx]   <= rs.insn;
            s_dst[free_idx]    <= rs.dst_tag;
            for (int j = 0; j < 2; j++) begin
                s_tag[free_idx][j]  <= rs.src_tag[j];
                s_rdy[free_idx][j]  <= in_rdy[j];
                s_data[free_idx][j] <= in_data[j];
            end
        end
        if (iss_found) begin
            o_issue_opcode      <= s_opcode[iss_idx];
            o_issue_tag         <= s_dst[iss_idx];
            o_issue_insn        <= s_insn[iss_idx];
            o_issue_iaddr       <= s_iaddr[iss_idx];
            o_issue_src_data[0] <= s_data[iss_idx][0];
            o_issue_src_data[1] <= s_data[iss_idx][1];
        end
    end

    // Dispatch has to see the stall before it writes
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(rs.en && rs.stall));

endmodule

// ==== rtl/ooo_dispatch_top.sv ====
// Top level of the issue front end
// Instruction queue, dispatch, ROB and reservation station

`timescale 1ns/1ps

module ooo_dispatch_top import ooo_pkg::*; (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_push,
    input  logic [XLEN-1:0]   i_insn,
    input  logic [XLEN-1:0]   i_iaddr,
    output logic              o_iq_full,
    // Result broadcast from the functional unit
    input  logic              i_cdb_valid,
    input  logic [TAG_W-1:0]  i_cdb_tag,
    input  logic [XLEN-1:0]   i_cdb_data,
    output logic              o_issue_valid,
    output opcode_t           o_issue_opcode,
    output logic [TAG_W-1:0]  o_issue_tag,
    output logic [XLEN-1:0]   o_issue_insn,
    output logic [XLEN-1:0]   o_issue_iaddr,
    output logic [XLEN-1:0]   o_issue_src_data [2],
    output logic              o_commit_valid,
    output rob_op_t           o_commit_op,
    output logic [REG_AW-1:0] o_commit_rdest,
    output logic [XLEN-1:0]   o_commit_data,
    output logic [XLEN-1:0]   o_commit_iaddr
);

    logic            iq_empty;
    logic [XLEN-1:0] iq_insn;
    logic [XLEN-1:0] iq_iaddr;
    logic            iq_pop;

    rob_dispatch_if rob_if ();
    rs_dispatch_if  rs_if ();

    insn_queue u_iq (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (i_push),
        .i_insn   (i_insn),
        .i_iaddr  (i_iaddr),
        .i_pop    (iq_pop),
        .o_empty  (iq_empty),
        .o_full   (o_iq_full),
        .o_insn   (iq_insn),
        .o_iaddr  (iq_iaddr)
    );

    dispatch u_disp (
        .i_empty (iq_empty),
        .i_insn  (iq_insn),
        .i_iaddr (iq_iaddr),
        .o_pop   (iq_pop),
        .rob     (rob_if.disp),
        .rs      (rs_if.disp)
    );

    rob u_rob (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .rob            (rob_if.rob),
        .i_cdb_valid    (i_cdb_valid),
        .i_cdb_tag      (i_cdb_tag),
        .i_cdb_data     (i_cdb_data),
        .o_commit_valid (o_commit_valid),
        .o_commit_op    (o_commit_op),
        .o_commit_rdest (o_commit_rdest),
        .o_commit_data  (o_commit_data),
        .o_commit_iaddr (o_commit_iaddr)
    );

    res_station u_rs (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .rs               (rs_if.rs),
        .i_cdb_valid      (i_cdb_valid),
        .i_cdb_tag        (i_cdb_tag),
        .i_cdb_data       (i_cdb_data),
        .o_issue_valid    (o_issue_valid),
        .o_issue_opcode   (o_issue_opcode),
        .o_issue_tag      (o_issue_tag),
        .o_issue_insn     (o_issue_insn),
        .o_issue_iaddr    (o_issue_iaddr),
        .o_issue_src_data (o_issue_src_data)
    );

endmodule

// ==== verif/tb_ooo_dispatch.sv ====
// Directed testbench for the dispatch front end
// Plays the functional unit, drives the CDB and checks issue and commit
// against a program-order scoreboard

`timescale 1ns/1ps

module tb_ooo_dispatch import ooo_pkg::*; ();

    localparam int MAXP           = 64;
    localparam int TIMEOUT_CYCLES = 2000;

    logic              clk;
    logic              i_arst_n;
    logic              i_push;
    logic [XLEN-1:0]   i_insn;
    logic [XLEN-1:0]   i_iaddr;
    logic              o_iq_full;
    logic              i_cdb_valid;
    logic [TAG_W-1:0]  i_cdb_tag;
    logic [XLEN-1:0]   i_cdb_data;
    logic              o_issue_valid;
    opcode_t           o_issue_opcode;
    logic [TAG_W-1:0]  o_issue_tag;
    logic [XLEN-1:0]   o_issue_insn;
    logic [XLEN-1:0]   o_issue_iaddr;
    logic [XLEN-1:0]   o_issue_src_data [2];
    logic              o_commit_valid;
    rob_op_t           o_commit_op;
    logic [REG_AW-1:0] o_commit_rdest;
    logic [XLEN-1:0]   o_commit_data;
    logic [XLEN-1:0]   o_commit_iaddr;

    // Scoreboard indexed by push order
    // The ROB tag of an operation is its index modulo ROB_DEPTH
    logic [XLEN-1:0]   p_insn    [MAXP];
    logic [XLEN-1:0]   p_iaddr   [MAXP];
    logic [6:0]        p_iss_op  [MAXP];
    logic [1:0]        p_rob_op  [MAXP];
    logic [REG_AW-1:0] p_rd      [MAXP];
    logic              p_use     [MAXP][2];
    int                p_prod    [MAXP][2];
    logic              issued    [MAXP];
    logic              res_known [MAXP];
    logic [XLEN-1:0]   result    [MAXP];
    int                last_wr   [NREGS];
    int                iss_q     [$];
    int                n_prog;
    int                n_commit;
    int                val_errs;
    int                other_errs;
    int                cycles;
    logic [31:0]       lcg_state;

    ooo_dispatch_top UUT (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_push           (i_push),
        .i_insn           (i_insn),
        .i_iaddr          (i_iaddr),
        .o_iq_full        (o_iq_full),
        .i_cdb_valid      (i_cdb_valid),
        .i_cdb_tag        (i_cdb_tag),
        .i_cdb_data       (i_cdb_data),
        .o_issue_valid    (o_issue_valid),
        .o_issue_opcode   (o_issue_opcode),
        .o_issue_tag      (o_issue_tag),
        .o_issue_insn     (o_issue_insn),
        .o_issue_iaddr    (o_issue_iaddr),
        .o_issue_src_data (o_issue_src_data),
        .o_commit_valid   (o_commit_valid),
        .o_commit_op      (o_commit_op),
        .o_commit_rdest   (o_commit_rdest),
        .o_commit_data    (o_commit_data),
        .o_commit_iaddr   (o_commit_iaddr)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
            val_errs++;
        end
    endtask

    task automatic flag_problem(input string msg);
        $display("%s at %0t", msg, $time);
        other_errs++;
    endtask

    // Records the expected behavior and pushes once the queue has room
    task automatic push_op(input logic [6:0] opc, input int rd, input int rs1, input int rs2);
        int                k;
        logic              u0;
        logic              u1;
        rob_op_t           cls;
        logic [REG_AW-1:0] rdv;
        logic [6:0]        iop;
        k   = n_prog;
        u0  = 1'b0;
        u1  = 1'b0;
        cls = ROB_OP_INT;
        rdv = REG_AW'(rd);
        iop = opc;
        case (opc)
            OPCODE_OPIMM:  u0 = 1'b1;
            OPCODE_LUI, OPCODE_AUIPC: ;
            OPCODE_OP: begin
                u0 = 1'b1;
                u1 = 1'b1;
            end
            OPCODE_JAL:    cls = ROB_OP_BR;
            OPCODE_JALR: begin
                u0  = 1'b1;
                cls = ROB_OP_BR;
            end
            OPCODE_BRANCH: begin
                u0  = 1'b1;
                u1  = 1'b1;
                cls = ROB_OP_BR;
                rdv = '0;
            end
            OPCODE_LOAD: begin
                u0  = 1'b1;
                cls = ROB_OP_LD;
            end
            OPCODE_STORE: begin
                u0  = 1'b1;
                u1  = 1'b1;
                cls = ROB_OP_ST;
                rdv = '0;
            end
            default: begin
                iop = OPCODE_OPIMM;
                rdv = '0;
            end
        endcase
        p_insn[k]    = {7'b0, REG_AW'(rs2), REG_AW'(rs1), 3'b0, REG_AW'(rd), opc};
        p_iaddr[k]   = 32'h1000 + 32'(4 * k);
        p_iss_op[k]  = iop;
        p_rob_op[k]  = cls;
        p_rd[k]      = rdv;
        p_use[k][0]  = u0;
        p_use[k][1]  = u1;
        // Latest earlier writer in program order or -1 for the reset value
        p_prod[k][0] = last_wr[rs1];
        p_prod[k][1] = last_wr[rs2];
        if (rdv != '0) begin
            last_wr[rd] = k;
        end
        n_prog++;
        @(negedge clk);
        while (o_iq_full) begin
            @(negedge clk);
        end
        @(posedge clk);
        i_push  <= 1'b1;
        i_insn  <= p_insn[k];
        i_iaddr <= p_iaddr[k];
        @(posedge clk);
        i_push <= 1'b0;
    endtask

    task automatic broadcast_result(input int k);
        int          idx;
        logic [31:0] val;
        idx = -1;
        foreach (iss_q[i]) begin
            if (iss_q[i] == k) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            flag_problem($sformatf("Result for operation %0d requested before it issued", k));
            return;
        end
        iss_q.delete(idx);
        val = lcg_next();
        @(posedge clk);
        i_cdb_valid  <= 1'b1;
        i_cdb_tag    <= TAG_W'(k % ROB_DEPTH);
        i_cdb_data   <= val;
        result[k]    = val;
        res_known[k] = 1'b1;
        @(posedge clk);
        i_cdb_valid <= 1'b0;
    endtask

    task automatic wait_issued(input int k);
        while (!issued[k]) begin
            @(posedge clk);
        end
    endtask

    // Completes issued work in issue order until everything pushed has committed
    task automatic drain_all();
        while (n_commit < n_prog) begin
            if (iss_q.size() > 0) begin
                broadcast_result(iss_q[0]);
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic score_issue();
        int          k;
        int          i;
        int          src;
        logic [31:0] want;
        // The tag picks the one in-flight operation inside the ROB window
        k = n_commit + ((int'(o_issue_tag) - n_commit) & (ROB_DEPTH - 1));
        if (k >= n_prog || issued[k]) begin
            flag_problem($sformatf("Issue of tag %0d matches no waiting operation", o_issue_tag));
            return;
        end
        issued[k] = 1'b1;
        iss_q.push_back(k);
        compare("o_issue_opcode", 32'(o_issue_opcode), 32'(p_iss_op[k]));
        compare("o_issue_insn", o_issue_insn, p_insn[k]);
        compare("o_issue_iaddr", o_issue_iaddr, p_iaddr[k]);
        for (i = 0; i < 2; i++) begin
            src = p_prod[k][i];
            if (p_use[k][i]) begin
                if (src >= 0 && !res_known[src]) begin
                    flag_problem($sformatf("Operation %0d issued before its source result", k));
                end else begin
                    want = (src < 0) ? 32'd0 : result[src];
                    compare($sformatf("o_issue_src_data[%0d]", i), o_issue_src_data[i], want);
                end
            end
        end
    endtask

    task automatic score_commit();
        int k;
        k = n_commit;
        if (k >= n_prog || !res_known[k]) begin
            flag_problem("Commit seen with no completed operation at the ROB head");
            return;
        end
        compare("o_commit_op", 32'(o_commit_op), 32'(p_rob_op[k]));
        compare("o_commit_rdest", 32'(o_commit_rdest), 32'(p_rd[k]));
        compare("o_commit_data", o_commit_data, result[k]);
        compare("o_commit_iaddr", o_commit_iaddr, p_iaddr[k]);
        n_commit++;
    endtask

    // Outputs are sampled mid-cycle with commits scored before issues
    always @(negedge clk) begin
        if (i_arst_n) begin
            if (o_commit_valid) begin
                score_commit();
            end
            if (o_issue_valid) begin
                score_issue();
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Closing counts: %0d value errors, %0d other errors", val_errs, other_errs);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge clk);
            compare("o_iq_full", 32'(o_iq_full), 32'd0);
            compare("o_issue_valid", 32'(o_issue_valid), 32'd0);
            compare("o_commit_valid", 32'(o_commit_valid), 32'd0);
        end
    endtask

    task automatic independent_ops();
        push_op(OPCODE_OPIMM, 1, 10, 0);
        push_op(OPCODE_LUI, 2, 0, 0);
        push_op(OPCODE_AUIPC, 3, 0, 0);
        push_op(OPCODE_OP, 4, 11, 12);
        push_op(OPCODE_JAL, 13, 0, 0);
        push_op(OPCODE_JALR, 14, 15, 0);
        drain_all();
    endtask

    task automatic load_use_dependence();
        int ld;
        int use_op;
        ld = n_prog;
        push_op(OPCODE_LOAD, 6, 0, 0);
        use_op = n_prog;
        push_op(OPCODE_OP, 7, 6, 6);
        wait_issued(ld);
        repeat (6) @(posedge clk);
        if (issued[use_op]) begin
            flag_problem("OP issued while the LOAD result was still outstanding");
        end
        broadcast_result(ld);
        wait_issued(use_op);
        drain_all();
        // Reader after the LOAD has committed sees the register file
        push_op(OPCODE_OPIMM, 8, 6, 0);
        drain_all();
    endtask

    task automatic reverse_completion();
        int first;
        int k;
        first = n_prog;
        for (k = 0; k < 4; k++) begin
            push_op(OPCODE_OPIMM, 16 + k, 0, 0);
        end
        for (k = first; k < first + 4; k++) begin
            wait_issued(k);
        end
        for (k = first + 3; k >= first; k--) begin
            broadcast_result(k);
        end
        drain_all();
    endtask

    task automatic rs_backpressure();
        int ld;
        int k;
        ld = n_prog;
        push_op(OPCODE_LOAD, 20, 0, 0);
        // Four readers fill the station and four more wait in the queue
        for (k = 0; k < 8; k++) begin
            push_op(OPCODE_OP, 21 + k, 20, 0);
        end
        @(negedge clk);
        compare("o_iq_full", 32'(o_iq_full), 32'd1);
        wait_issued(ld);
        broadcast_result(ld);
        drain_all();
    endtask

    task automatic no_dest_ops();
        push_op(OPCODE_OPIMM, 9, 0, 0);
        drain_all();
        // Bits [11:7] point at x9 but none of these may write it
        push_op(OPCODE_STORE, 9, 9, 9);
        push_op(OPCODE_BRANCH, 9, 9, 0);
        push_op(7'h7f, 9, 0, 0);
        drain_all();
        push_op(OPCODE_OP, 10, 9, 9);
        drain_all();
    endtask

    initial begin
        clk         = 1'b0;
        i_arst_n    = 1'b0;
        i_push      = 1'b0;
        i_insn      = '0;
        i_iaddr     = '0;
        i_cdb_valid = 1'b0;
        i_cdb_tag   = '0;
        i_cdb_data  = '0;
        lcg_state   = 32'h8d53;
        n_prog      = 0;
        n_commit    = 0;
        val_errs    = 0;
        other_errs  = 0;
        cycles      = 0;
        for (int r = 0; r < NREGS; r++) begin
            last_wr[r] = -1;
        end
        for (int k = 0; k < MAXP; k++) begin
            issued[k]    = 1'b0;
            res_known[k] = 1'b0;
        end
        repeat (3) @(posedge clk);
        i_arst_n <= 1'b1;

        idle_after_reset();
        independent_ops();
        load_use_dependence();
        reverse_completion();
        rs_backpressure();
        no_dest_ops();

        repeat (5) @(posedge clk);
        $display("Closing counts: %0d value errors, %0d other errors", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/ooo_pkg.sv
rtl/ooo_ifs.sv
rtl/insn_queue.sv
rtl/dispatch.sv
rtl/rob.sv
rtl/res_station.sv
rtl/ooo_dispatch_top.sv
verif/tb_ooo_dispatch.sv

// ==== Makefile ====
# Verilator build and run for the dispatch front end testbench

TOP = tb_ooo_dispatch
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
